// ==== include/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define CORE_XLEN       32   // data and address width.
`define CORE_REG_AW     5
`define CORE_DMEM_WORDS 256  // data memory depth in words.

// execute cycles taken by one multiply.
`define CORE_MUL_CYCLES 3

`define CORE_STALL_W    6    // pc, fetch, decode, execute, memory, writeback.

`endif

// ==== project.f ====
+incdir+include
src/core_pkg.sv
src/alu_exec.sv
src/alu_lsu.sv
src/lsu.sv
src/stall_ctrl.sv
src/core_backend.sv
tb/tb_core_backend.sv

// ==== src/alu_exec.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module alu_exec (
    input  logic                     clk,
    input  logic                     rst_n,
    input  core_pkg::alu_op_e        alu_op_i,
    input  core_pkg::mem_op_e        mem_op_i,
    input  logic [`CORE_XLEN-1:0]    op_a_i,
    input  logic [`CORE_XLEN-1:0]    op_b_i,
    input  logic [`CORE_XLEN-1:0]    imm_i,
    input  logic                     wr_reg_en_i,
    input  logic [`CORE_REG_AW-1:0]  wr_reg_addr_i,
    input  logic [`CORE_STALL_W-1:0] stall_i,
    output logic [`CORE_XLEN-1:0]    reg_wdata_o,
    output logic                     wr_reg_en_o,
    output logic [`CORE_REG_AW-1:0]  wr_reg_addr_o,
    output logic                     wr_mem_en_o,
    output logic                     rd_mem_en_o,
    output core_pkg::mem_op_e        mem_op_o,
    output logic [`CORE_XLEN-1:0]    mem_addr_o,
    output logic [1:0]               wr_addr_index_o,
    output logic [1:0]               rd_addr_index_o,
    output logic [`CORE_XLEN-1:0]    wr_mem_data_o,
    output logic                     stall_req_o
);
    import core_pkg::*;

    localparam int CNT_W = $clog2(`CORE_MUL_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CORE_MUL_CYCLES - 1);

    logic [CNT_W-1:0]     mul_cnt;
    logic [`CORE_XLEN-1:0] mul_lo;
    logic                 is_mul;
    logic [4:0]           shamt;

    assign is_mul = (alu_op_i == ALU_MUL);
    assign shamt  = op_b_i[4:0];
    assign mul_lo = op_a_i * op_b_i;  // low half is sign agnostic.

    // ~~~~~~~~~~~~~~~~~~~~
    // arithmetic
    always_comb begin
        case (alu_op_i)
            ALU_ADD:  reg_wdata_o = op_a_i + op_b_i;
            ALU_SUB:  reg_wdata_o = op_a_i - op_b_i;
            ALU_AND:  reg_wdata_o = op_a_i & op_b_i;
            ALU_OR:   reg_wdata_o = op_a_i | op_b_i;
            ALU_XOR:  reg_wdata_o = op_a_i ^ op_b_i;
            ALU_SLL:  reg_wdata_o = op_a_i << shamt;
            ALU_SRL:  reg_wdata_o = op_a_i >> shamt;
            ALU_SRA:  reg_wdata_o = $signed(op_a_i) >>> shamt;
            ALU_SLT:  reg_wdata_o = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
            ALU_SLTU: reg_wdata_o = {{(`CORE_XLEN-1){1'b0}}, op_a_i < op_b_i};
            ALU_MUL:  reg_wdata_o = (mul_cnt == CNT_LAST) ? mul_lo : '0;
            ALU_LUI:  reg_wdata_o = imm_i;
            default:  reg_wdata_o = '0;
        endcase
    end

    // multiply occupancy counter frozen while memory stalls.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_cnt <= '0;
        end else if (is_mul && !stall_i[4]) begin
            mul_cnt <= (mul_cnt == CNT_LAST) ? '0 : mul_cnt + 1'b1;
        end
    end

    assign stall_req_o = is_mul && (mul_cnt != CNT_LAST);

    // ~~~~~~~~~~~~~~~~~~~~
    // load / store address and data
    assign wr_mem_en_o     = mem_op_i inside {MEM_SB, MEM_SH, MEM_SW};
    assign rd_mem_en_o     = mem_op_i inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    assign mem_op_o        = mem_op_i;
    assign mem_addr_o      = op_a_i + imm_i;
    assign wr_addr_index_o = mem_addr_o[1:0];
    assign rd_addr_index_o = mem_addr_o[1:0];

    always_comb begin
        case (mem_op_i)
            MEM_SB:  wr_mem_data_o = {4{op_b_i[7:0]}};   // every lane.
            MEM_SH:  wr_mem_data_o = {2{op_b_i[15:0]}};
            default: wr_mem_data_o = op_b_i;
        endcase
    end

    assign wr_reg_en_o   = wr_reg_en_i;
    assign wr_reg_addr_o = wr_reg_addr_i;

    mul_no_mem_a: assert property (@(posedge clk) disable iff (!rst_n)
        is_mul |-> mem_op_i == MEM_NONE)
        else $error("multiply issued with a memory opcode.");

endmodule

// ==== src/alu_lsu.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module alu_lsu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CORE_XLEN-1:0]    reg_wdata_i,
    input  logic                     wr_reg_en_i,
    input  logic [`CORE_REG_AW-1:0]  wr_reg_addr_i,
    input  logic                     wr_mem_en_i,
    input  logic                     rd_mem_en_i,
    input  core_pkg::mem_op_e        mem_op_i,
    input  logic [`CORE_XLEN-1:0]    mem_addr_i,
    input  logic [1:0]               wr_addr_index_i,
    input  logic [1:0]               rd_addr_index_i,
    input  logic [`CORE_XLEN-1:0]    wr_mem_data_i,
    input  logic [`CORE_XLEN-1:0]    alu_pc_i,
    input  logic [`CORE_XLEN-1:0]    alu_inst_i,
    input  logic [`CORE_STALL_W-1:0] stall_i,
    output logic [`CORE_XLEN-1:0]    lsu_reg_wdata_o,
    output logic                     lsu_wr_reg_en_o,
    output logic [`CORE_REG_AW-1:0]  lsu_wr_reg_addr_o,
    output logic                     lsu_wr_mem_en_o,
    output logic                     lsu_rd_mem_en_o,
    output core_pkg::mem_op_e        lsu_mem_op_o,
    output logic [`CORE_XLEN-1:0]    lsu_mem_addr_o,
    output logic [1:0]               lsu_wr_addr_index_o,
    output logic [1:0]               lsu_rd_addr_index_o,
    output logic [`CORE_XLEN-1:0]    lsu_wr_mem_data_o,
    output logic [`CORE_XLEN-1:0]    lsu_pc_o,
    output logic [`CORE_XLEN-1:0]    lsu_inst_o
);
    import core_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lsu_reg_wdata_o     <= '0;
            lsu_wr_reg_en_o     <= 1'b0;
            lsu_wr_reg_addr_o   <= '0;
            lsu_wr_mem_en_o     <= 1'b0;
            lsu_rd_mem_en_o     <= 1'b0;
            lsu_mem_op_o        <= MEM_NONE;
            lsu_mem_addr_o      <= '0;
            lsu_wr_addr_index_o <= '0;
            lsu_rd_addr_index_o <= '0;
            lsu_wr_mem_data_o   <= '0;
            lsu_pc_o            <= '0;
            lsu_inst_o          <= '0;
        end else if (stall_i[3] && !stall_i[4]) begin  // bubble while execute is stuck.
            lsu_reg_wdata_o     <= '0;
            lsu_wr_reg_en_o     <= 1'b0;
            lsu_wr_reg_addr_o   <= '0;
            lsu_wr_mem_en_o     <= 1'b0;
            lsu_rd_mem_en_o     <= 1'b0;
            lsu_mem_op_o        <= MEM_NONE;
            lsu_mem_addr_o      <= '0;
            lsu_wr_addr_index_o <= '0;
            lsu_rd_addr_index_o <= '0;
            lsu_wr_mem_data_o   <= '0;
            lsu_pc_o            <= '0;
            lsu_inst_o          <= '0;
        end else if (!stall_i[3]) begin
            lsu_reg_wdata_o     <= reg_wdata_i;
            lsu_wr_reg_en_o     <= wr_reg_en_i;
            lsu_wr_reg_addr_o   <= wr_reg_addr_i;
            lsu_wr_mem_en_o     <= wr_mem_en_i;
            lsu_rd_mem_en_o     <= rd_mem_en_i;
            lsu_mem_op_o        <= mem_op_i;
            lsu_mem_addr_o      <= mem_addr_i;
            lsu_wr_addr_index_o <= wr_addr_index_i;
            lsu_rd_addr_index_o <= rd_addr_index_i;
            lsu_wr_mem_data_o   <= wr_mem_data_i;
            lsu_pc_o            <= alu_pc_i;
            lsu_inst_o          <= alu_inst_i;
        end
    end

    rd_wr_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(lsu_wr_mem_en_o && lsu_rd_mem_en_o))
        else $error("load and store enables both set.");

    // this register holds while the memory stage is stalled.
    hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i[4] |=> $stable({lsu_reg_wdata_o, lsu_wr_reg_en_o, lsu_wr_reg_addr_o,
                                lsu_wr_mem_en_o, lsu_rd_mem_en_o, lsu_mem_op_o,
                                lsu_mem_addr_o, lsu_wr_addr_index_o, lsu_rd_addr_index_o,
                                lsu_wr_mem_data_o, lsu_pc_o, lsu_inst_o}))
        else $error("execute/memory register changed under stall.");

endmodule

// ==== src/core_backend.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module core_backend (
    input  logic                     clk,
    input  logic                     rst_n,
    input  core_pkg::alu_op_e        alu_op_i,
    input  core_pkg::mem_op_e        mem_op_i,
    input  logic [`CORE_XLEN-1:0]    op_a_i,
    input  logic [`CORE_XLEN-1:0]    op_b_i,
    input  logic [`CORE_XLEN-1:0]    imm_i,
    input  logic [`CORE_XLEN-1:0]    pc_i,
    input  logic [`CORE_XLEN-1:0]    inst_i,
    input  logic                     wr_reg_en_i,
    input  logic [`CORE_REG_AW-1:0]  wr_reg_addr_i,
    input  logic                     stall_req_id_i,
    output logic [`CORE_STALL_W-1:0] stall_o,
    output logic                     wb_en_o,
    output logic [`CORE_REG_AW-1:0]  wb_addr_o,
    output logic [`CORE_XLEN-1:0]    wb_data_o,
    output logic [`CORE_XLEN-1:0]    wb_pc_o,
    output logic [`CORE_XLEN-1:0]    wb_inst_o
);
    import core_pkg::*;

    // execute outputs.
    logic [`CORE_XLEN-1:0]   reg_wdata;
    logic                    ex_wr_reg_en;
    logic [`CORE_REG_AW-1:0] ex_wr_reg_addr;
    logic                    ex_wr_mem_en;
    logic                    ex_rd_mem_en;
    mem_op_e                 ex_mem_op;
    logic [`CORE_XLEN-1:0]   ex_mem_addr;
    logic [1:0]              ex_wr_addr_index;
    logic [1:0]              ex_rd_addr_index;
    logic [`CORE_XLEN-1:0]   ex_wr_mem_data;
    logic                    stall_req_ex;

    // memory stage inputs.
    logic [`CORE_XLEN-1:0]   lsu_reg_wdata;
    logic                    lsu_wr_reg_en;
    logic [`CORE_REG_AW-1:0] lsu_wr_reg_addr;
    logic                    lsu_wr_mem_en;
    logic                    lsu_rd_mem_en;
    mem_op_e                 lsu_mem_op;
    logic [`CORE_XLEN-1:0]   lsu_mem_addr;
    logic [1:0]              lsu_wr_addr_index;
    logic [1:0]              lsu_rd_addr_index;
    logic [`CORE_XLEN-1:0]   lsu_wr_mem_data;
    logic [`CORE_XLEN-1:0]   lsu_pc;
    logic [`CORE_XLEN-1:0]   lsu_inst;
    logic                    stall_req_lsu;

    alu_exec u_alu_exec (
        .clk             (clk),
        .rst_n           (rst_n),
        .alu_op_i        (alu_op_i),
        .mem_op_i        (mem_op_i),
        .op_a_i          (op_a_i),
        .op_b_i          (op_b_i),
        .imm_i           (imm_i),
        .wr_reg_en_i     (wr_reg_en_i),
        .wr_reg_addr_i   (wr_reg_addr_i),
        .stall_i         (stall_o),
        .reg_wdata_o     (reg_wdata),
        .wr_reg_en_o     (ex_wr_reg_en),
        .wr_reg_addr_o   (ex_wr_reg_addr),
        .wr_mem_en_o     (ex_wr_mem_en),
        .rd_mem_en_o     (ex_rd_mem_en),
        .mem_op_o        (ex_mem_op),
        .mem_addr_o      (ex_mem_addr),
        .wr_addr_index_o (ex_wr_addr_index),
        .rd_addr_index_o (ex_rd_addr_index),
        .wr_mem_data_o   (ex_wr_mem_data),
        .stall_req_o     (stall_req_ex)
    );

    alu_lsu u_alu_lsu (
        .clk                 (clk),
        .rst_n               (rst_n),
        .reg_wdata_i         (reg_wdata),
        .wr_reg_en_i         (ex_wr_reg_en),
        .wr_reg_addr_i       (ex_wr_reg_addr),
        .wr_mem_en_i         (ex_wr_mem_en),
        .rd_mem_en_i         (ex_rd_mem_en),
        .mem_op_i            (ex_mem_op),
        .mem_addr_i          (ex_mem_addr),
        .wr_addr_index_i     (ex_wr_addr_index),
        .rd_addr_index_i     (ex_rd_addr_index),
        .wr_mem_data_i       (ex_wr_mem_data),
        .alu_pc_i            (pc_i),
        .alu_inst_i          (inst_i),
        .stall_i             (stall_o),
        .lsu_reg_wdata_o     (lsu_reg_wdata),
        .lsu_wr_reg_en_o     (lsu_wr_reg_en),
        .lsu_wr_reg_addr_o   (lsu_wr_reg_addr),
        .lsu_wr_mem_en_o     (lsu_wr_mem_en),
        .lsu_rd_mem_en_o     (lsu_rd_mem_en),
        .lsu_mem_op_o        (lsu_mem_op),
        .lsu_mem_addr_o      (lsu_mem_addr),
        .lsu_wr_addr_index_o (lsu_wr_addr_index),
        .lsu_rd_addr_index_o (lsu_rd_addr_index),
        .lsu_wr_mem_data_o   (lsu_wr_mem_data),
        .lsu_pc_o            (lsu_pc),
        .lsu_inst_o          (lsu_inst)
    );

    lsu u_lsu (
        .clk             (clk),
        .rst_n           (rst_n),
        .reg_wdata_i     (lsu_reg_wdata),
        .wr_reg_en_i     (lsu_wr_reg_en),
        .wr_reg_addr_i   (lsu_wr_reg_addr),
        .wr_mem_en_i     (lsu_wr_mem_en),
        .rd_mem_en_i     (lsu_rd_mem_en),
        .mem_op_i        (lsu_mem_op),
        .mem_addr_i      (lsu_mem_addr),
        .wr_addr_index_i (lsu_wr_addr_index),
        .rd_addr_index_i (lsu_rd_addr_index),
        .wr_mem_data_i   (lsu_wr_mem_data),
        .pc_i            (lsu_pc),
        .inst_i          (lsu_inst),
        .stall_i         (stall_o),
        .stall_req_o     (stall_req_lsu),
        .wb_en_o         (wb_en_o),
        .wb_addr_o       (wb_addr_o),
        .wb_data_o       (wb_data_o),
        .wb_pc_o         (wb_pc_o),
        .wb_inst_o       (wb_inst_o)
    );

    stall_ctrl u_stall_ctrl (
        .stall_req_id_i  (stall_req_id_i),
        .stall_req_ex_i  (stall_req_ex),
        .stall_req_lsu_i (stall_req_lsu),
        .stall_o         (stall_o)
    );

endmodule

// ==== src/core_pkg.sv ====
package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_MUL  = 4'd10,
        ALU_LUI  = 4'd11   // immediate passes through.
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

endpackage

// ==== src/lsu.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module lsu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CORE_XLEN-1:0]    reg_wdata_i,
    input  logic                     wr_reg_en_i,
    input  logic [`CORE_REG_AW-1:0]  wr_reg_addr_i,
    input  logic                     wr_mem_en_i,
    input  logic                     rd_mem_en_i,
    input  core_pkg::mem_op_e        mem_op_i,
    input  logic [`CORE_XLEN-1:0]    mem_addr_i,
    input  logic [1:0]               wr_addr_index_i,
    input  logic [1:0]               rd_addr_index_i,
    input  logic [`CORE_XLEN-1:0]    wr_mem_data_i,
    input  logic [`CORE_XLEN-1:0]    pc_i,
    input  logic [`CORE_XLEN-1:0]    inst_i,
    input  logic [`CORE_STALL_W-1:0] stall_i,
    output logic                     stall_req_o,
    output logic                     wb_en_o,
    output logic [`CORE_REG_AW-1:0]  wb_addr_o,
    output logic [`CORE_XLEN-1:0]    wb_data_o,
    output logic [`CORE_XLEN-1:0]    wb_pc_o,
    output logic [`CORE_XLEN-1:0]    wb_inst_o
);
    import core_pkg::*;

    localparam int IDX_W = $clog2(`CORE_DMEM_WORDS);

    logic [`CORE_XLEN-1:0] mem [`CORE_DMEM_WORDS];
    logic [`CORE_XLEN-1:0] rd_data;
    logic [IDX_W-1:0]      word_idx;
    logic [3:0]            byte_en;
    logic                  phase;     // second cycle of an access.
    logic                  st_fire;
    logic [7:0]            ld_byte;
    logic [15:0]           ld_half;
    logic [`CORE_XLEN-1:0] ld_data;

    assign word_idx = mem_addr_i[IDX_W+1:2];
    assign st_fire  = wr_mem_en_i && !phase;  // one write per store.

    always_comb begin
        case (mem_op_i)
            MEM_SB:  byte_en = 4'b0001 << wr_addr_index_i;
            MEM_SH:  byte_en = wr_addr_index_i[1] ? 4'b1100 : 4'b0011;
            MEM_SW:  byte_en = 4'b1111;
            default: byte_en = 4'b0000;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // data memory
    always_ff @(posedge clk) begin
        if (st_fire) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= wr_mem_data_i[8*b +: 8];
                end
            end
        end
        rd_data <= mem[word_idx];
    end

    // only a load's first cycle raises bit 4.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= 1'b0;
        end else begin
            phase <= stall_i[4];
        end
    end

    assign stall_req_o = rd_mem_en_i && !phase;

    // lane select and extension.
    assign ld_byte = rd_data[8*rd_addr_index_i +: 8];
    assign ld_half = rd_addr_index_i[1] ? rd_data[31:16] : rd_data[15:0];

    always_comb begin
        case (mem_op_i)
            MEM_LB:  ld_data = {{24{ld_byte[7]}}, ld_byte};
            MEM_LBU: ld_data = {24'b0, ld_byte};
            MEM_LH:  ld_data = {{16{ld_half[15]}}, ld_half};
            MEM_LHU: ld_data = {16'b0, ld_half};
            default: ld_data = rd_data;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // memory to writeback register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en_o   <= 1'b0;
            wb_addr_o <= '0;
            wb_data_o <= '0;
            wb_pc_o   <= '0;
            wb_inst_o <= '0;
        end else if (stall_i[4] && !stall_i[5]) begin
            wb_en_o   <= 1'b0;
            wb_addr_o <= '0;
            wb_data_o <= '0;
            wb_pc_o   <= '0;
            wb_inst_o <= '0;
        end else if (!stall_i[4]) begin
            wb_en_o   <= wr_reg_en_i;
            wb_addr_o <= wr_reg_addr_i;
            wb_data_o <= rd_mem_en_i ? ld_data : reg_wdata_i;
            wb_pc_o   <= pc_i;
            wb_inst_o <= inst_i;
        end
    end

    single_stall_a: assert property (@(posedge clk) disable iff (!rst_n)
        stall_req_o |=> !stall_req_o)
        else $error("load stall held for more than one cycle.");

endmodule

// ==== src/stall_ctrl.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module stall_ctrl (
    input  logic                     stall_req_id_i,
    input  logic                     stall_req_ex_i,
    input  logic                     stall_req_lsu_i,
    output logic [`CORE_STALL_W-1:0] stall_o
);

    // deepest requester wins and everything upstream of it holds.
    always_comb begin
        if (stall_req_lsu_i) begin
            stall_o = 6'b01_1111;
        end else if (stall_req_ex_i) begin
            stall_o = 6'b00_1111;
        end else if (stall_req_id_i) begin
            stall_o = 6'b00_0111;
        end else begin
            stall_o = 6'b00_0000;
        end
    end

    stall_therm_a: assert final (((stall_o & (stall_o + 6'd1)) == 6'd0) && !stall_o[5])
        else $error("stall vector not a thermometer code: %b", stall_o);

endmodule

// ==== tb/tb_core_backend.sv ====
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_core_backend;
    import core_pkg::*;

    typedef struct packed {
        logic [4:0]  addr;
        logic [31:0] data;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] cyc;  // sampled cycle count at which it must show up.
    } wb_rec_t;

    logic        clk;
    logic        rst_n;
    alu_op_e     alu_op;
    mem_op_e     mem_op;
    logic [31:0] op_a, op_b, imm, pc, inst;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic        id_stall;
    logic [5:0]  stall_o;
    logic        wb_en_o;
    logic [4:0]  wb_addr_o;
    logic [31:0] wb_data_o, wb_pc_o, wb_inst_o;

    logic [31:0] cyc;
    logic [31:0] pc_cnt;
    logic        prev_load;
    logic [31:0] mem_model [64];
    wb_rec_t     exp_q [$];
    wb_rec_t     head;
    logic        head_valid;

    core_backend dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .alu_op_i       (alu_op),
        .mem_op_i       (mem_op),
        .op_a_i         (op_a),
        .op_b_i         (op_b),
        .imm_i          (imm),
        .pc_i           (pc),
        .inst_i         (inst),
        .wr_reg_en_i    (wr_en),
        .wr_reg_addr_i  (wr_addr),
        .stall_req_id_i (id_stall),
        .stall_o        (stall_o),
        .wb_en_o        (wb_en_o),
        .wb_addr_o      (wb_addr_o),
        .wb_data_o      (wb_data_o),
        .wb_pc_o        (wb_pc_o),
        .wb_inst_o      (wb_inst_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // scoreboard head retires on each writeback.
    always @(posedge clk) begin
        if (head_valid && wb_en_o && exp_q.size() > 0) begin
            exp_q.delete(0);
        end
        head_valid = (exp_q.size() > 0);
        if (head_valid) head = exp_q[0];
    end

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "check failed.");
    endtask

    task automatic report_timeout(input string msg);
        $display("timed out at %0t ns while %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "timeout.");
    endtask

    wb_match_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en_o |-> head_valid && wb_addr_o == head.addr && wb_data_o == head.data &&
                    wb_pc_o == head.pc && wb_inst_o == head.inst)
        else report_error("writeback differs from the next expected instruction");

    wb_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_en_o && head_valid) |-> cyc == head.cyc)
        else report_error("writeback arrived on the wrong cycle");

    stall_shape_a: assert property (@(posedge clk) disable iff (!rst_n)
        stall_o inside {6'b00_0000, 6'b00_0111, 6'b00_1111, 6'b01_1111})
        else report_error("stall vector has an unexpected shape");

    function automatic logic [31:0] isa_result(input alu_op_e aop, input logic [31:0] a,
                                               input logic [31:0] b, input logic [31:0] im);
        case (aop)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_MUL:  return a * b;
            default:  return im;  // lui.
        endcase
    endfunction

    // present one slot on the falling edge and hold it until execute takes it.
    task automatic send_slot(input alu_op_e aop, input mem_op_e mop, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] im, input logic wen,
                             input logic [4:0] wad, input logic idst,
                             input logic [31:0] exp_data);
        int unsigned t;
        logic [5:0]  exp_stall;
        logic        is_ld;
        wb_rec_t     rec;
        @(negedge clk);
        pc_cnt   = pc_cnt + 4;
        alu_op   = aop;
        mem_op   = mop;
        op_a     = a;
        op_b     = b;
        imm      = im;
        wr_en    = wen;
        wr_addr  = wad;
        id_stall = idst;
        pc       = pc_cnt;
        inst     = $urandom;
        is_ld    = mop inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
        if (wen) begin
            rec.addr = wad;
            rec.data = exp_data;
            rec.pc   = pc;
            rec.inst = inst;
            rec.cyc  = cyc + 2 + (aop == ALU_MUL ? `CORE_MUL_CYCLES - 1 : 0)
                       + (is_ld ? 1 : 0) + (prev_load ? 1 : 0);
            exp_q.push_back(rec);
        end
        #1;
        exp_stall = prev_load ? 6'b01_1111 :
                    (aop == ALU_MUL) ? 6'b00_1111 :
                    idst ? 6'b00_0111 : 6'b00_0000;
        assert (stall_o == exp_stall)
            else report_error($sformatf("stall_o %b, expected %b", stall_o, exp_stall));
        t = 0;
        while (stall_o[3] && t < 20) begin
            @(negedge clk);
            #1;
            t++;
        end
        if (t >= 20) begin
            report_timeout("waiting for execute to accept an instruction");
        end
        prev_load = is_ld;
    endtask

    task automatic send_empty(input logic idst);
        send_slot(ALU_ADD, MEM_NONE, 32'd0, 32'd0, 32'd0, 1'b0, 5'd0, idst, 32'd0);
    endtask

    task automatic send_store(input mem_op_e mop, input logic [7:0] addr,
                              input logic [31:0] data);
        logic [31:0] im;
        logic [31:0] w;
        im = $urandom_range(0, 31);
        w  = mem_model[addr[7:2]];
        case (mop)
            MEM_SB:  w[8*addr[1:0] +: 8] = data[7:0];
            MEM_SH:  w[16*addr[1] +: 16] = data[15:0];
            default: w = data;
        endcase
        mem_model[addr[7:2]] = w;
        send_slot(ALU_ADD, mop, {24'd0, addr} - im, data, im, 1'b0, 5'd0, 1'b0, 32'd0);
    endtask

    task automatic send_load(input mem_op_e mop, input logic [7:0] addr, input logic [4:0] rd);
        logic [31:0] im;
        logic [31:0] w;
        logic [7:0]  by;
        logic [15:0] hw;
        logic [31:0] exp_v;
        im = $urandom_range(0, 31);
        w  = mem_model[addr[7:2]];
        by = w[8*addr[1:0] +: 8];
        hw = w[16*addr[1] +: 16];
        case (mop)
            MEM_LB:  exp_v = {{24{by[7]}}, by};
            MEM_LBU: exp_v = {24'd0, by};
            MEM_LH:  exp_v = {{16{hw[15]}}, hw};
            MEM_LHU: exp_v = {16'd0, hw};
            default: exp_v = w;
        endcase
        send_slot(ALU_ADD, mop, {24'd0, addr} - im, $urandom, im, 1'b1, rd, 1'b0, exp_v);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus
    initial begin
        int unsigned t;
        int unsigned k;
        alu_op_e     aop;
        mem_op_e     mop;
        logic [31:0] a, b, im;
        logic [7:0]  addr;
        void'($urandom(41040));
        clk       = 1'b0;
        rst_n     = 1'b0;
        cyc       = '0;
        pc_cnt    = 32'h0000_1000;
        prev_load = 1'b0;
        head      = '0;
        head_valid = 1'b0;
        alu_op    = ALU_ADD;
        mem_op    = MEM_NONE;
        op_a      = '0;
        op_b      = '0;
        imm       = '0;
        pc        = '0;
        inst      = '0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        id_stall  = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        assert (wb_en_o == 1'b0 && stall_o == 6'd0 && wb_pc_o == 32'd0)
            else report_error("outputs not idle after reset");

        repeat (12) send_empty(1'b0);
        for (int w = 0; w < 64; w++) begin
            send_store(MEM_SW, 8'(w * 4), 32'h5A00_0000 ^ (w * 32'h0103_0507));
        end
        repeat (4) send_empty(1'b1);

        for (int n = 0; n < 320; n++) begin
            k = $urandom_range(0, 9);
            if (k <= 3 || k == 9) begin
                aop = (k == 9) ? ALU_MUL : alu_op_e'(4'($urandom_range(0, 11)));
                a   = $urandom;
                b   = ($urandom_range(0, 1) == 0) ? $urandom_range(0, 40) : $urandom;
                im  = $urandom;
                send_slot(aop, MEM_NONE, a, b, im, 1'b1, 5'($urandom_range(1, 4)), 1'b0,
                          isa_result(aop, a, b, im));
            end else if (k <= 6) begin
                mop  = mem_op_e'(4'($urandom_range(1, 8)));
                addr = 8'($urandom_range(0, 63) * 4);
                if (mop inside {MEM_LB, MEM_LBU, MEM_SB}) addr[1:0] = 2'($urandom_range(0, 3));
                if (mop inside {MEM_LH, MEM_LHU, MEM_SH}) addr[1] = 1'($urandom_range(0, 1));
                if (mop inside {MEM_SB, MEM_SH, MEM_SW}) begin
                    send_store(mop, addr, $urandom);
                end else begin
                    send_load(mop, addr, 5'($urandom_range(1, 4)));
                end
            end else begin
                send_empty(k == 8);
            end
        end

        repeat (8) send_empty(1'b0);
        t = 0;
        while (exp_q.size() > 0 && t < 100) begin
            @(negedge clk);
            t++;
        end
        if (t >= 100) begin
            report_timeout("waiting for the last writebacks");
        end
        repeat (4) @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
